// ==== trs_bus_pkg.sv ====
`default_nettype none

package trs_bus_pkg;

  // z80 i/o port map, model III
  localparam logic [7:0] TRS_IO_PORT     = 8'h1F;
  localparam logic [7:0] FREHD_BASE      = 8'hC0; // 16 ports
  localparam logic [7:0] PRINTER_BASE    = 8'hF8; // 2 ports
  localparam logic [7:0] CASS_PORT       = 8'hFF;
  localparam logic [7:0] ORCH_L_PORT     = 8'h75;
  localparam logic [7:0] ORCH_R_PORT     = 8'h79;
  localparam logic [7:0] FLASH_CTRL_PORT = 8'hFC;
  localparam logic [7:0] FLASH_DATA_PORT = 8'hFD;

  typedef struct packed {
    logic [7:0] a;       // low address byte
    logic [7:0] d;       // data from the z80
    logic       in_n;
    logic       out_n;
    logic       ioreq_n;
  } z80_bus_t;

  typedef struct packed {
    logic trs_io_in;
    logic trs_io_out;
    logic frehd_in;
    logic frehd_out;
    logic printer_rd;
    logic printer_wr;
    logic cass_out;
    logic orch_l_out;
    logic orch_r_out;
    logic flash_ctrl_out;
    logic flash_data_in;
    logic flash_data_out;
    logic io_access;     // one cycle per bus access
  } port_sel_t;

  // code on ESP_S, tells the esp which port was hit
  typedef enum logic [3:0] {
    ESP_TRS_IO_IN  = 4'd0,
    ESP_TRS_IO_OUT = 4'd1,
    ESP_FREHD_IN   = 4'd2,
    ESP_FREHD_OUT  = 4'd3,
    ESP_PRINTER_RD = 4'd4,
    ESP_PRINTER_WR = 4'd5,
    ESP_IDLE       = 4'hF
  } esp_func_t;

  // flash control byte: cs active high, wpn active low
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic       cs;
      logic       wpn;
      logic [5:0] unused;
    } f;
  } flash_ctrl_u;

endpackage

`default_nettype wire

// ==== host_cmd_pkg.sv ====
`default_nettype none

package host_cmd_pkg;

  typedef enum logic [7:0] {
    OP_GET_COOKIE       = 8'd0,
    OP_DBUS_READ        = 8'd3,
    OP_DBUS_WRITE       = 8'd4,
    OP_DATA_READY       = 8'd5,
    OP_GET_VERSION      = 8'd15,
    OP_GET_MODE         = 8'd16,
    OP_ABUS_READ        = 8'd18,
    OP_SET_LED          = 8'd26,
    OP_GET_CONFIG       = 8'd27,
    OP_SET_SPI_CTRL_REG = 8'd29,
    OP_SET_SPI_DATA     = 8'd30,
    OP_GET_SPI_DATA     = 8'd31,
    OP_SET_VPRINTER_EN  = 8'd33
  } host_op_t;

  typedef struct packed {
    logic       stb;   // one cycle per command
    host_op_t   op;
    logic [7:0] param;
  } host_cmd_t;

  localparam logic [7:0] COOKIE        = 8'hAF;
  localparam logic [2:0] VERSION_MAJOR = 3'd0;
  localparam logic [4:0] VERSION_MINOR = 5'd3;
  localparam logic [3:0] TRS_MODE      = 4'h8; // model III

  // number of parameter bytes after the opcode
  function automatic logic param_count(host_op_t op);
    case (op)
      OP_DBUS_WRITE, OP_SET_LED, OP_SET_SPI_CTRL_REG,
      OP_SET_SPI_DATA, OP_SET_VPRINTER_EN: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== port_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_decoder
  import trs_bus_pkg::*;
(
  input  wire       clk,
  input  wire       rst_n,
  input  z80_bus_t  bus,
  input  wire       vprinter_en,
  output port_sel_t sel,
  output logic      dbus_dir
);

  logic       rd;
  logic       wr;
  logic       trs_io_hit;
  logic       frehd_hit;
  logic       printer_hit;
  logic [2:0] acc_sync;  // [1:0] synchroniser, [2] edge history
  logic       io_access_q;

  assign rd = ~bus.in_n & ~bus.ioreq_n;
  assign wr = ~bus.out_n & ~bus.ioreq_n;

  assign dbus_dir = bus.in_n | bus.ioreq_n; // low while the z80 reads

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_sync    <= 3'b000;
      io_access_q <= 1'b0;
    end else begin
      acc_sync    <= {acc_sync[1:0], rd | wr};
      io_access_q <= acc_sync[1] & ~acc_sync[2]; // rising edge only
    end
  end

  assign trs_io_hit  = (bus.a == TRS_IO_PORT);
  assign frehd_hit   = (bus.a[7:4] == FREHD_BASE[7:4]);
  assign printer_hit = vprinter_en & (bus.a[7:1] == PRINTER_BASE[7:1]);

  always_comb begin
    sel.trs_io_in      = trs_io_hit & rd;
    sel.trs_io_out     = trs_io_hit & wr;
    sel.frehd_in       = frehd_hit & rd;
    sel.frehd_out      = frehd_hit & wr;
    sel.printer_rd     = printer_hit & rd;
    sel.printer_wr     = printer_hit & wr;
    sel.cass_out       = (bus.a == CASS_PORT) & wr;
    sel.orch_l_out     = (bus.a == ORCH_L_PORT) & wr;
    sel.orch_r_out     = (bus.a == ORCH_R_PORT) & wr;
    sel.flash_ctrl_out = (bus.a == FLASH_CTRL_PORT) & wr;
    sel.flash_data_in  = (bus.a == FLASH_DATA_PORT) & rd;
    sel.flash_data_out = (bus.a == FLASH_DATA_PORT) & wr;
    sel.io_access      = io_access_q;
  end

endmodule

`default_nettype wire

// ==== esp_handshake.sv ====
`timescale 1ns/1ps
`default_nettype none

module esp_handshake
  import trs_bus_pkg::*;
#(
  parameter int ESP_REQ_CYCLES = 50
) (
  input  wire       clk,
  input  wire       rst_n,
  input  port_sel_t sel,
  input  wire       esp_done,
  output esp_func_t esp_s,
  output logic      esp_req,
  output logic      wait_req,
  output logic      extiosel
);

  localparam int CW = $clog2(ESP_REQ_CYCLES + 1);

  logic          esp_sel;
  logic          esp_start;
  logic [2:0]    done_sync;
  logic          done_rise;
  logic [CW-1:0] req_cnt;

  assign esp_sel = sel.trs_io_in | sel.trs_io_out | sel.frehd_in |
                   sel.frehd_out | sel.printer_rd | sel.printer_wr;
  assign esp_start = sel.io_access & esp_sel;
  assign done_rise = done_sync[1] & ~done_sync[2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_sync <= 3'b000;
      req_cnt   <= '0;
      wait_req  <= 1'b0;
    end else begin
      done_sync <= {done_sync[1:0], esp_done};
      if (esp_start)
        req_cnt <= CW'(ESP_REQ_CYCLES); // a new access restarts the pulse
      else if (req_cnt != '0)
        req_cnt <= req_cnt - 1'b1;
      if (esp_start)
        wait_req <= 1'b1;
      else if (done_rise)
        wait_req <= 1'b0;
    end
  end

  assign esp_req = (req_cnt != '0);

  // esp reads and flash data reads drive the bus
  assign extiosel = sel.trs_io_in | sel.frehd_in | sel.printer_rd | sel.flash_data_in;

  always_comb begin
    if (sel.trs_io_in)       esp_s = ESP_TRS_IO_IN;
    else if (sel.trs_io_out) esp_s = ESP_TRS_IO_OUT;
    else if (sel.frehd_in)   esp_s = ESP_FREHD_IN;
    else if (sel.frehd_out)  esp_s = ESP_FREHD_OUT;
    else if (sel.printer_rd) esp_s = ESP_PRINTER_RD;
    else if (sel.printer_wr) esp_s = ESP_PRINTER_WR;
    else                     esp_s = ESP_IDLE;
  end

endmodule

`default_nettype wire

// ==== spi_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_slave (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        cs_n,
  input  wire        sck,
  input  wire        mosi,
  output logic [7:0] rx_byte,
  output logic       rx_valid,
  input  wire  [7:0] tx_byte,
  output logic       miso
);

  logic [2:0] sck_r;
  logic [1:0] cs_r;
  logic [1:0] mosi_r;   // lines up with sck_r[1]
  logic       sck_rise;
  logic       sck_fall;
  logic       active;
  logic [2:0] bitcnt;
  logic [7:0] tx_sh;

  assign sck_rise = (sck_r[2:1] == 2'b01);
  assign sck_fall = (sck_r[2:1] == 2'b10);
  assign active   = ~cs_r[1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sck_r    <= 3'b000;
      cs_r     <= 2'b11;
      mosi_r   <= 2'b00;
      bitcnt   <= 3'd0;
      rx_valid <= 1'b0;
    end else begin
      sck_r    <= {sck_r[1:0], sck};
      cs_r     <= {cs_r[0], cs_n};
      mosi_r   <= {mosi_r[0], mosi};
      rx_valid <= 1'b0;
      if (!active)
        bitcnt <= 3'd0;
      else if (sck_rise) begin
        bitcnt <= bitcnt + 3'd1;
        if (bitcnt == 3'd7)
          rx_valid <= 1'b1;
      end
    end
  end

  // bits move in on sck rise, out on sck fall
  always_ff @(posedge clk) begin
    if (active && sck_rise)
      rx_byte <= {rx_byte[6:0], mosi_r[1]};
    if (active && sck_fall) begin
      if (bitcnt == 3'd1)
        tx_sh <= tx_byte;      // first falling edge of the byte
      else
        tx_sh <= {tx_sh[6:0], 1'b0};
    end
  end

  assign miso = active ? tx_sh[7] : 1'bz;

endmodule

`default_nettype wire

// ==== cmd_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_parser
  import host_cmd_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  input  wire  [7:0] rx_byte,
  input  wire        rx_valid,
  output host_cmd_t  cmd,
  output logic       bad_op
);

  typedef enum logic {
    S_IDLE,
    S_PARAM
  } state_t;

  state_t   state;
  host_op_t op_in;
  logic     known;

  assign op_in = host_op_t'(rx_byte);

  always_comb begin
    case (rx_byte)
      OP_GET_COOKIE, OP_DBUS_READ, OP_DBUS_WRITE, OP_DATA_READY,
      OP_GET_VERSION, OP_GET_MODE, OP_ABUS_READ, OP_SET_LED,
      OP_GET_CONFIG, OP_SET_SPI_CTRL_REG, OP_SET_SPI_DATA,
      OP_GET_SPI_DATA, OP_SET_VPRINTER_EN: known = 1'b1;
      default: known = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= S_IDLE;
      cmd    <= '0;
      bad_op <= 1'b0;
    end else begin
      cmd.stb <= 1'b0;
      bad_op  <= 1'b0;
      if (rx_valid) begin
        case (state)
          S_IDLE: begin
            if (!known)
              bad_op <= 1'b1;     // dropped, stays idle
            else begin
              cmd.op <= op_in;
              if (param_count(op_in))
                state <= S_PARAM;
              else
                cmd.stb <= 1'b1;
            end
          end
          S_PARAM: begin
            cmd.param <= rx_byte;
            cmd.stb   <= 1'b1;
            state     <= S_IDLE;
          end
          default: state <= S_IDLE;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== host_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_regs
  import trs_bus_pkg::*;
  import host_cmd_pkg::*;
#(
  parameter int HEARTBEAT_BITS = 26
) (
  input  wire        clk,
  input  wire        rst_n,
  input  host_cmd_t  cmd,
  input  wire        bad_op,
  input  port_sel_t  sel,
  input  z80_bus_t   bus,
  input  wire  [3:0] conf,
  input  wire  [7:0] flash_rx,
  output logic [7:0] tx_byte,
  output logic [7:0] d_out,
  output logic       dbus_en_n,
  output logic       vprinter_en,
  output logic       int_req,
  output logic       led_red,
  output logic       led_green,
  output logic       led_blue,
  output logic       led_hb
);

  logic [7:0]                trs_data;  // byte returned on esp reads
  logic                      spi_error;
  logic [HEARTBEAT_BITS-1:0] heartbeat;
  logic                      esp_rd;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vprinter_en <= 1'b1;
      int_req     <= 1'b0;
      {led_blue, led_green, led_red} <= 3'b000;
      spi_error   <= 1'b0;
      heartbeat   <= '0;
    end else begin
      heartbeat <= heartbeat + 1'b1;
      if (bad_op)
        spi_error <= 1'b1;   // sticky
      if (sel.io_access && (sel.trs_io_in || sel.trs_io_out))
        int_req <= 1'b0;
      if (cmd.stb) begin
        case (cmd.op)
          OP_DATA_READY:      int_req <= 1'b1;
          OP_SET_VPRINTER_EN: vprinter_en <= cmd.param[0];
          OP_SET_LED:         {led_blue, led_green, led_red} <= cmd.param[2:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd.stb && cmd.op == OP_DBUS_WRITE)
      trs_data <= cmd.param;
    if (cmd.stb) begin
      case (cmd.op)
        OP_GET_COOKIE:   tx_byte <= COOKIE;
        OP_GET_VERSION:  tx_byte <= {VERSION_MAJOR, VERSION_MINOR};
        OP_GET_MODE:     tx_byte <= {4'b0000, TRS_MODE};
        OP_GET_CONFIG:   tx_byte <= {4'b0000, ~conf};
        OP_DBUS_READ:    tx_byte <= bus.d;
        OP_ABUS_READ:    tx_byte <= bus.a;
        OP_GET_SPI_DATA: tx_byte <= flash_rx;
        default: ;
      endcase
    end
  end

  assign led_hb = heartbeat[HEARTBEAT_BITS-1] | spi_error;

  // z80 read path
  assign esp_rd = sel.trs_io_in | sel.frehd_in | sel.printer_rd;
  assign dbus_en_n = ~(~(bus.out_n | bus.ioreq_n) | esp_rd | sel.flash_data_in);

  always_comb begin
    if (esp_rd)
      d_out = trs_data;
    else if (sel.flash_data_in)
      d_out = flash_rx;
    else
      d_out = 8'h00;
  end

endmodule

`default_nettype wire

// ==== flash_spi_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module flash_spi_master
  import trs_bus_pkg::*;
  import host_cmd_pkg::*;
#(
  parameter int FLASH_HALF_CYCLES = 8
) (
  input  wire        clk,
  input  wire        rst_n,
  input  port_sel_t  sel,
  input  z80_bus_t   bus,
  input  host_cmd_t  cmd,
  output logic [7:0] flash_rx,
  output logic       flash_cs_n,
  output logic       flash_sck,
  output logic       flash_si,
  input  wire        flash_so
);

  localparam int HW = (FLASH_HALF_CYCLES > 1) ? $clog2(FLASH_HALF_CYCLES) : 1;

  flash_ctrl_u   ctrl;
  logic          busy;
  logic [HW-1:0] half_cnt;   // cycles within a half period
  logic [3:0]    phase;      // 16 half periods, odd ones have sck high
  logic [7:0]    shift;
  logic          port_wr;
  logic          cmd_wr;

  assign port_wr = sel.io_access & sel.flash_data_out;
  assign cmd_wr  = cmd.stb & (cmd.op == OP_SET_SPI_DATA);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl.raw <= 8'h00;
      busy     <= 1'b0;
      half_cnt <= '0;
      phase    <= 4'd0;
      flash_si <= 1'b0;
    end else begin
      if (sel.io_access && sel.flash_ctrl_out)
        ctrl.raw <= bus.d;
      else if (cmd.stb && cmd.op == OP_SET_SPI_CTRL_REG)
        ctrl.raw <= cmd.param;

      if (busy) begin
        if (half_cnt == HW'(FLASH_HALF_CYCLES - 1)) begin
          half_cnt <= '0;
          phase    <= phase + 4'd1;
          if (phase == 4'd15)
            busy <= 1'b0;
        end else
          half_cnt <= half_cnt + 1'b1;
        if (half_cnt == '0 && !phase[0])
          flash_si <= shift[7];   // msb first, set up while sck is low
      end else if (port_wr || cmd_wr) begin
        busy     <= 1'b1;
        half_cnt <= '0;
        phase    <= 4'd0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (busy && half_cnt == '0 && phase[0])
      shift <= {shift[6:0], flash_so};
    else if (!busy && port_wr)
      shift <= bus.d;
    else if (!busy && cmd_wr)
      shift <= cmd.param;
  end

  assign flash_rx   = shift;
  assign flash_cs_n = ~ctrl.f.cs;
  assign flash_sck  = busy & phase[0];

endmodule

`default_nettype wire

// ==== cass_audio.sv ====
`timescale 1ns/1ps
`default_nettype none

module cass_audio
  import trs_bus_pkg::*;
(
  input  wire       clk,
  input  wire       rst_n,
  input  port_sel_t sel,
  input  z80_bus_t  bus,
  output logic      cass_out_l,
  output logic      cass_out_r
);

  logic [1:0] cass;
  logic [7:0] orch [2];  // 0 left, 1 right
  logic [1:0] level;     // signed -1, 0 or +1
  logic [1:0] pdm_out;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cass <= 2'b00;
      orch <= '{default: 8'h00};
    end else if (sel.io_access) begin
      if (sel.cass_out)
        cass <= bus.d[1:0];
      if (sel.orch_l_out)
        orch[0] <= bus.d;
      if (sel.orch_r_out)
        orch[1] <= bus.d;
    end
  end

  // bit1 inverted plus bit0, centred on zero
  assign level = {1'b0, ~cass[1]} + {1'b0, cass[0]} - 2'b01;

  for (genvar ch = 0; ch < 2; ch++) begin : g_chan
    logic [8:0] sample;  // signed mix
    logic [9:0] acc;     // carry out is the pdm bit

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        sample <= 9'd0;
        acc    <= 10'd0;
      end else begin
        sample <= {orch[ch][7], orch[ch]} + {level, 7'b0000000};
        acc    <= {1'b0, acc[8:0]} + {1'b0, ~sample[8], sample[7:0]}; // offset binary
      end
    end

    assign pdm_out[ch] = acc[9];
  end

  assign cass_out_l = pdm_out[0];
  assign cass_out_r = pdm_out[1];

endmodule

`default_nettype wire

// ==== trs_io_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module trs_io_top
  import trs_bus_pkg::*;
  import host_cmd_pkg::*;
#(
  parameter int ESP_REQ_CYCLES    = 50,
  parameter int HEARTBEAT_BITS    = 26,
  parameter int FLASH_HALF_CYCLES = 8
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire  [7:0] a,
  input  wire  [7:0] d_in,
  input  wire        in_n,
  input  wire        out_n,
  input  wire        ioreq_n,
  output logic [7:0] d_out,
  output logic       dbus_en_n,
  output logic       dbus_dir,
  input  wire        cs_fpga,
  input  wire        sck,
  input  wire        mosi,
  output logic       miso,
  output logic [3:0] esp_s,
  output logic       esp_req,
  input  wire        esp_done,
  output logic       int_req,
  output logic       wait_req,
  output logic       extiosel,
  input  wire  [3:0] conf,
  output logic [3:0] led,
  output logic       led_red,
  output logic       led_green,
  output logic       led_blue,
  output logic       flash_cs_n,
  output logic       flash_sck,
  output logic       flash_si,
  input  wire        flash_so,
  output logic       cass_out_l,
  output logic       cass_out_r
);

  z80_bus_t   bus;
  port_sel_t  sel;
  esp_func_t  esp_func;
  host_cmd_t  cmd;
  logic       vprinter_en;
  logic       bad_op;
  logic       led_hb;
  logic       rx_valid;
  logic [7:0] rx_byte;
  logic [7:0] tx_byte;
  logic [7:0] flash_rx;

  assign bus = '{a: a, d: d_in, in_n: in_n, out_n: out_n, ioreq_n: ioreq_n};

  assign esp_s  = esp_func;
  assign led[0] = (esp_func != ESP_IDLE); // esp activity
  assign led[1] = wait_req;
  assign led[2] = int_req;
  assign led[3] = led_hb;

  port_decoder i_port_decoder (
    .clk(clk), .rst_n(rst_n), .bus(bus), .vprinter_en(vprinter_en),
    .sel(sel), .dbus_dir(dbus_dir)
  );

  esp_handshake #(.ESP_REQ_CYCLES(ESP_REQ_CYCLES)) i_esp_handshake (
    .clk(clk), .rst_n(rst_n), .sel(sel), .esp_done(esp_done),
    .esp_s(esp_func), .esp_req(esp_req), .wait_req(wait_req), .extiosel(extiosel)
  );

  spi_slave i_spi_slave (
    .clk(clk), .rst_n(rst_n), .cs_n(cs_fpga), .sck(sck), .mosi(mosi),
    .rx_byte(rx_byte), .rx_valid(rx_valid), .tx_byte(tx_byte), .miso(miso)
  );

  cmd_parser i_cmd_parser (
    .clk(clk), .rst_n(rst_n), .rx_byte(rx_byte), .rx_valid(rx_valid),
    .cmd(cmd), .bad_op(bad_op)
  );

  host_regs #(.HEARTBEAT_BITS(HEARTBEAT_BITS)) i_host_regs (
    .clk(clk), .rst_n(rst_n), .cmd(cmd), .bad_op(bad_op), .sel(sel), .bus(bus),
    .conf(conf), .flash_rx(flash_rx), .tx_byte(tx_byte), .d_out(d_out),
    .dbus_en_n(dbus_en_n), .vprinter_en(vprinter_en), .int_req(int_req),
    .led_red(led_red), .led_green(led_green), .led_blue(led_blue), .led_hb(led_hb)
  );

  flash_spi_master #(.FLASH_HALF_CYCLES(FLASH_HALF_CYCLES)) i_flash_spi_master (
    .clk(clk), .rst_n(rst_n), .sel(sel), .bus(bus), .cmd(cmd), .flash_rx(flash_rx),
    .flash_cs_n(flash_cs_n), .flash_sck(flash_sck), .flash_si(flash_si),
    .flash_so(flash_so)
  );

  cass_audio i_cass_audio (
    .clk(clk), .rst_n(rst_n), .sel(sel), .bus(bus),
    .cass_out_l(cass_out_l), .cass_out_r(cass_out_r)
  );

endmodule

`default_nettype wire

// ==== trs_io_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module trs_io_asserts
  import trs_bus_pkg::*;
#(
  parameter int ESP_REQ_CYCLES = 50
) (
  input wire       clk,
  input wire       rst_n,
  input port_sel_t sel,
  input z80_bus_t  bus,
  input wire       esp_req,
  input wire       wait_req,
  input wire       flash_cs_n,
  input wire       cs_fpga,
  input wire       miso_en
);

  logic esp_start;
  int   high_cnt;   // cycles of the current request pulse

  assign esp_start = sel.io_access & (sel.trs_io_in | sel.trs_io_out | sel.frehd_in |
                     sel.frehd_out | sel.printer_rd | sel.printer_wr);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      high_cnt <= 0;
    else if (esp_start)
      high_cnt <= 0;
    else if (esp_req)
      high_cnt <= high_cnt + 1;
    else
      high_cnt <= 0;
  end

  a_wait_rise: assert property (@(posedge clk) disable iff (!rst_n)
    esp_start |=> wait_req) else $error("wait_req missing after esp access");

  a_req_len: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(esp_req) |-> high_cnt == ESP_REQ_CYCLES) else $error("esp_req length wrong");

  a_flash_cs: assert property (@(posedge clk) disable iff (!rst_n)
    sel.io_access && sel.flash_ctrl_out |=> flash_cs_n == !$past(bus.d[7]))
    else $error("flash_cs_n does not follow ctrl bit");

  // miso driver off while cs is high
  a_miso_z: assert property (@(posedge clk) disable iff (!rst_n)
    cs_fpga && $past(cs_fpga) && $past(cs_fpga, 2) |-> !miso_en)
    else $error("miso driven while cs high");

endmodule

bind trs_io_top trs_io_asserts #(.ESP_REQ_CYCLES(ESP_REQ_CYCLES)) i_asserts (
  .clk(clk), .rst_n(rst_n), .sel(sel), .bus(bus), .esp_req(esp_req),
  .wait_req(wait_req), .flash_cs_n(flash_cs_n), .cs_fpga(cs_fpga),
  .miso_en(i_spi_slave.active)
);

`default_nettype wire

// ==== tb_trs_io.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_trs_io;

  localparam int ESP_REQ_CYCLES    = 50;
  localparam int FLASH_HALF_CYCLES = 8;
  localparam int N_ROUNDS          = 6;
  // rough cost of each test step in clock cycles
  localparam int SPI_BYTE_CYCLES   = 8 * 14 + 16;
  localparam int BUS_CYCLES        = 120;
  localparam int FLASH_CYCLES      = 16 * FLASH_HALF_CYCLES + 40;
  localparam int AUDIO_CYCLES      = 512 + 100;
  localparam int RESET_CYCLES      = 15;
  localparam int ROUND_CYCLES      = 24 * SPI_BYTE_CYCLES + 12 * BUS_CYCLES +
                                     FLASH_CYCLES + AUDIO_CYCLES + RESET_CYCLES;
  localparam int MAX_CYCLES        = 2 * N_ROUNDS * ROUND_CYCLES + 200;

  logic clk = 1'b0;
  logic rst_n;
  logic [7:0] a, d_in, d_out;
  logic in_n, out_n, ioreq_n, dbus_en_n, dbus_dir;
  logic cs_fpga, sck, mosi, esp_done, esp_req, int_req, wait_req, extiosel;
  wire  miso;
  logic [3:0] esp_s, conf, led;
  logic led_red, led_green, led_blue;
  logic flash_cs_n, flash_sck, flash_si, flash_so, cass_out_l, cass_out_r;

  integer seed = 12;
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  logic [7:0] flash_ret;    // byte the modelled flash returns
  logic [7:0] si_bits;
  int sck_count;
  logic prev_sck;

  always #5 clk = ~clk;

  trs_io_top #(.ESP_REQ_CYCLES(ESP_REQ_CYCLES), .HEARTBEAT_BITS(26),
               .FLASH_HALF_CYCLES(FLASH_HALF_CYCLES)) i_dut (.*);

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // flash model, SO frozen while sck is high
  always @(negedge clk) begin
    if (flash_sck && !prev_sck) begin
      si_bits = {si_bits[6:0], flash_si};
      sck_count++;
    end
    if (!flash_sck && sck_count < 8)
      flash_so = flash_ret[7 - sck_count];
    prev_sck = flash_sck;
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic check_val(input string name, input logic [15:0] got,
                           input logic [15:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
      errors++;
      $display("error at %0t ns: %s", $time, msg);
    end
  endtask

  // reset for 10 cycles, then the idle outputs
  task automatic apply_reset();
    rst_n = 1'b0;
    wait_cycles(10);
    rst_n = 1'b1;
    wait_cycles(5);
    check_val("led", led, 4'h0);
    check_val("wait_req", wait_req, 1'b0);
    check_val("esp_req", esp_req, 1'b0);
    check_val("int_req", int_req, 1'b0);
    check_val("led_rgb", {led_blue, led_green, led_red}, 3'b000);
    check_val("flash_cs_n", flash_cs_n, 1'b1);
  endtask

  // one byte on the esp link, mode 0, msb first
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    cs_fpga = 1'b0;
    wait_cycles(4);
    for (int i = 7; i >= 0; i--) begin
      mosi = tx[i];
      wait_cycles(4);
      sck = 1'b1;
      wait_cycles(4);
      sck = 1'b0;
      wait_cycles(6);
      rx[i] = miso;   // after falling edge 8-i
    end
    wait_cycles(6);
    cs_fpga = 1'b1;
    wait_cycles(4);
  endtask

  task automatic send_cmd(input logic [7:0] op);
    logic [7:0] dummy;
    spi_byte(op, dummy);
  endtask

  task automatic send_cmd_param(input logic [7:0] op, input logic [7:0] param);
    send_cmd(op);
    send_cmd(param);
  endtask

  task automatic query(input logic [7:0] op, input logic [7:0] exp, input string name);
    logic [7:0] rx;
    send_cmd(op);
    spi_byte(8'h00, rx);  // filler byte carries the reply
    check_val(name, rx, exp);
  endtask

  function automatic logic is_known(input logic [7:0] op);
    case (op)
      8'd0, 8'd3, 8'd4, 8'd5, 8'd15, 8'd16, 8'd18,
      8'd26, 8'd27, 8'd29, 8'd30, 8'd31, 8'd33: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  task automatic bus_start(input logic rd, input logic [7:0] addr, input logic [7:0] data);
    a       = addr;
    d_in    = data;
    ioreq_n = 1'b0;
    in_n    = ~rd;
    out_n   = rd;
  endtask

  task automatic bus_end();
    ioreq_n = 1'b1;
    in_n    = 1'b1;
    out_n   = 1'b1;
    wait_cycles(4);
  endtask

  task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
    bus_start(1'b0, addr, data);
    wait_cycles(5);
    bus_end();
  endtask

  // z80 access served by the esp, held by WAIT until esp_done
  task automatic esp_access(input logic rd, input logic [7:0] addr,
                            input logic [3:0] code, input logic [7:0] rd_data);
    int n;
    bus_start(rd, addr, $random(seed));
    wait_cycles(5);
    check_val("esp_s", esp_s, code);
    check_val("extiosel", extiosel, rd);
    check_val("wait_req", wait_req, 1'b1);
    check_val("esp_req", esp_req, 1'b1);
    check_val("led[0]", led[0], 1'b1);
    check_val("led[1]", led[1], 1'b1);
    check_val("dbus_dir", dbus_dir, !rd);
    if (rd) begin
      check_val("d_out", d_out, rd_data);
      check_val("dbus_en_n", dbus_en_n, 1'b0);
    end
    n = 2 + ($random(seed) & 15);
    repeat (n) begin
      wait_cycles(1);
      check_true(wait_req, "wait_req fell before esp_done");
    end
    esp_done = 1'b1;
    n = 0;
    while (wait_req && n < 20) begin
      wait_cycles(1);
      n++;
    end
    check_true(!wait_req, "wait_req did not fall after esp_done");
    esp_done = 1'b0;
    bus_end();
    n = 0;
    while (esp_req && n < 2 * ESP_REQ_CYCLES) begin
      wait_cycles(1);
      n++;
    end
    check_true(!esp_req, "esp_req did not end");
  endtask

  task automatic flash_test();
    logic [7:0] ctrl, tx;
    int n;
    ctrl = $random(seed);
    bus_write(8'hFC, ctrl);
    check_val("flash_cs_n", flash_cs_n, !ctrl[7]);
    tx        = $random(seed);
    flash_ret = $random(seed);
    sck_count = 0;
    si_bits   = 8'h00;
    bus_start(1'b0, 8'hFD, tx);
    n = 0;
    while (sck_count < 8 && n < FLASH_CYCLES) begin
      wait_cycles(1);
      n++;
    end
    check_true(sck_count == 8, "flash transfer did not give 8 sck pulses");
    bus_end();
    wait_cycles(FLASH_HALF_CYCLES + 4);
    check_val("flash_si", si_bits, tx);
    bus_start(1'b1, 8'hFD, 8'h00);
    wait_cycles(5);
    check_val("extiosel", extiosel, 1'b1);
    check_val("d_out", d_out, flash_ret);
    check_val("dbus_en_n", dbus_en_n, 1'b0);
    bus_end();
    query(8'd31, flash_ret, "get_spi_data");
  endtask

  task automatic audio_test();
    logic [1:0] cass;
    logic [7:0] orch_l, orch_r;
    int level, exp_l, exp_r, cnt_l, cnt_r;
    cass   = $random(seed);
    orch_l = $random(seed);
    orch_r = $random(seed);
    bus_write(8'hFF, {6'b0, cass});
    bus_write(8'h75, orch_l);
    bus_write(8'h79, orch_r);
    wait_cycles(10);
    level = (cass[1] ? 0 : 1) + (cass[0] ? 1 : 0) - 1;
    exp_l = $signed(orch_l) + level * 128 + 256;  // duty times 512
    exp_r = $signed(orch_r) + level * 128 + 256;
    cnt_l = 0;
    cnt_r = 0;
    repeat (512) begin
      wait_cycles(1);
      cnt_l += cass_out_l;
      cnt_r += cass_out_r;
    end
    checks += 2;
    assert (cnt_l >= exp_l - 2 && cnt_l <= exp_l + 2) else begin
      errors++;
      $display("mismatch at %0t ns: cass_out_l got %0d expected %0d", $time, cnt_l, exp_l);
    end
    assert (cnt_r >= exp_r - 2 && cnt_r <= exp_r + 2) else begin
      errors++;
      $display("mismatch at %0t ns: cass_out_r got %0d expected %0d", $time, cnt_r, exp_r);
    end
  endtask

  initial begin
    logic [7:0] p, dbus, op;
    int kind;
    rst_n = 1'b0;
    a = 8'h00;
    d_in = 8'h00;
    {in_n, out_n, ioreq_n} = 3'b111;
    {cs_fpga, sck, mosi} = 3'b100;
    esp_done = 1'b0;
    conf = 4'h0;
    flash_so = 1'b0;
    flash_ret = 8'h00;
    si_bits = 8'h00;
    sck_count = 8;
    prev_sck = 1'b0;
    for (int r = 0; r < N_ROUNDS; r++) begin
      apply_reset();  // error flag starts clear every round
      query(8'd0, 8'hAF, "get_cookie");
      query(8'd15, 8'h03, "get_version");
      query(8'd16, 8'h08, "get_mode");
      conf = $random(seed);
      query(8'd27, {4'h0, ~conf}, "get_config");
      p = $random(seed);
      send_cmd_param(8'd26, p);
      check_val("led_red", led_red, p[0]);
      check_val("led_green", led_green, p[1]);
      check_val("led_blue", led_blue, p[2]);
      do op = $random(seed); while (is_known(op));
      send_cmd(op);
      wait_cycles(2);
      check_val("led[3]", led[3], 1'b1);
      dbus = $random(seed);
      send_cmd_param(8'd4, dbus);
      send_cmd_param(8'd33, 8'h01);
      repeat (4) begin
        kind = $unsigned($random(seed)) % 3;
        p = $random(seed);
        case (kind)
          0: esp_access(p[7], 8'h1F, {3'd0, ~p[7]}, dbus);
          1: esp_access(p[7], {4'hC, p[3:0]}, {3'd1, ~p[7]}, dbus);
          default: esp_access(p[7], {7'h7C, p[0]}, {3'd2, ~p[7]}, dbus);
        endcase
      end
      send_cmd_param(8'd33, 8'h00);
      p = $random(seed);
      bus_start(p[7], {7'h7C, p[0]}, 8'h00);
      wait_cycles(5);
      check_val("esp_s", esp_s, 4'hF);
      check_val("extiosel", extiosel, 1'b0);
      check_val("wait_req", wait_req, 1'b0);
      check_val("led[0]", led[0], 1'b0);
      bus_end();
      send_cmd(8'd5);
      check_val("int_req", int_req, 1'b1);
      check_val("led[2]", led[2], 1'b1);
      esp_access(1'b0, 8'h1F, 4'd1, dbus);
      check_val("int_req", int_req, 1'b0);
      check_val("led[2]", led[2], 1'b0);
      flash_test();
      audio_test();
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
trs_bus_pkg.sv
host_cmd_pkg.sv
port_decoder.sv
esp_handshake.sv
spi_slave.sv
cmd_parser.sv
host_regs.sv
flash_spi_master.sv
cass_audio.sv
trs_io_top.sv
trs_io_asserts.sv
tb_trs_io.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_trs_io \
  -f tb.f -o sim_trs_io > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_trs_io > sim.log 2>&1 || true

grep -q "^STATUS: PASS$" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
